/* files.f */
hw/lcd_pkg.sv
hw/lcd_ctrl.sv
hw/lcd_init_seq.sv
hw/lcd_fill_dri.sv
hw/lcd_signal_sel.sv
hw/lcd_top.sv
test/lcd_chk.sv
test/lcd_tb.sv

/* hw/lcd_ctrl.sv */
//----------------------------------------------------------------------------
// LCD control block
// APB register file, fill start gating and busy tracking
//----------------------------------------------------------------------------

`timescale 1ns/1ns

module lcd_ctrl import lcd_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        init_done,
    input  logic        fill_busy,
    input  logic [15:0] panel_id,
    output logic        fill_start,
    output logic        bl,
    output lcd_word_u   color,
    output logic [7:0]  x0,
    output logic [7:0]  y0,
    output logic [7:0]  w,
    output logic [7:0]  h
);

    logic        addr_hit;
    logic        wr_en;
    logic        rd_setup;
    logic        busy;          // Start issued, fill not yet finished
    logic        fill_busy_d;
    logic [31:0] rd_mux;

    assign pready   = 1'b1;                         // No wait states
    assign wr_en    = psel & penable & pwrite;
    assign rd_setup = psel & ~penable & ~pwrite;    // Load read data a cycle early

    always_comb begin
        case (paddr)
            REG_CTRL, REG_STATUS, REG_ID, REG_COLOR, REG_RECT: addr_hit = 1'b1;
            default: addr_hit = 1'b0;
        endcase
    end

    assign pslverr = psel & penable & ~addr_hit;

    // ------------------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------------------
    always_comb begin
        case (paddr)
            REG_CTRL:   rd_mux = {30'd0, bl, 1'b0};        // Start reads as 0
            REG_STATUS: rd_mux = {30'd0, busy, init_done};
            REG_ID:     rd_mux = {16'd0, panel_id};
            REG_COLOR:  rd_mux = {16'd0, color.raw};
            REG_RECT:   rd_mux = {h, w, y0, x0};
            default:    rd_mux = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prdata <= 32'd0;
        end else if (rd_setup) begin
            prdata <= rd_mux;                       // Valid through access phase
        end
    end

    // ------------------------------------------------------------------------
    // Write side and start sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bl          <= 1'b0;
            color.raw   <= 16'd0;
            {h, w, y0, x0} <= 32'd0;
            fill_start  <= 1'b0;
            busy        <= 1'b0;
            fill_busy_d <= 1'b0;
        end else begin
            fill_start  <= 1'b0;                    // One cycle pulse
            fill_busy_d <= fill_busy;
            if (fill_busy_d && !fill_busy)
                busy <= 1'b0;                       // Fill finished
            if (wr_en) begin
                case (paddr)
                    REG_CTRL: begin
                        bl <= pwdata[1];
                        // Ignore start while busy or before panel ready
                        if (pwdata[0] && init_done && !busy) begin
                            fill_start <= 1'b1;
                            busy       <= 1'b1;
                        end
                    end
                    REG_COLOR: color.raw      <= pwdata[15:0];
                    REG_RECT:  {h, w, y0, x0} <= pwdata;
                    default: ;                      // STATUS, ID read only
                endcase
            end
        end
    end

endmodule

/* hw/lcd_fill_dri.sv */
//----------------------------------------------------------------------------
// LCD fill driver
// Window commands, memory write, then w*h words of one colour
//----------------------------------------------------------------------------

`timescale 1ns/1ns

module lcd_fill_dri import lcd_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fill_start,
    input  lcd_word_u   color,
    input  logic [7:0]  x0,
    input  logic [7:0]  y0,
    input  logic [7:0]  w,
    input  logic [7:0]  h,
    output logic        fill_busy,
    output logic        mlcd_cs_dri,        // Active low
    output logic        mlcd_wr_dri,        // Active low
    output logic        mlcd_rs_dri,
    output logic [15:0] mlcd_data_dri
);

    // Word index: 0 col cmd, 1-4 x, 5 row cmd, 6-9 y, 10 mem write, 11 pixels
    logic [3:0]  idx;
    logic [3:0]  nxt_idx;
    logic        nxt_rs;
    logic [15:0] nxt_data;
    logic [7:0]  xs_r;
    logic [7:0]  ys_r;
    logic [15:0] xe_r;
    logic [15:0] ye_r;
    lcd_word_u   color_r;
    logic [15:0] pix_left;

    // ------------------------------------------------------------------------
    // Next word on the bus
    // ------------------------------------------------------------------------
    always_comb begin
        nxt_idx = (idx == 4'd11) ? 4'd11 : idx + 4'd1;
        nxt_rs  = 1'b1;                     // Parameters and pixels
        case (nxt_idx)
            4'd1:    nxt_data = 16'h0000;   // Start is 8 bits, high byte 0
            4'd2:    nxt_data = {8'h00, xs_r};
            4'd3:    nxt_data = {8'h00, xe_r[15:8]};
            4'd4:    nxt_data = {8'h00, xe_r[7:0]};
            4'd5: begin
                nxt_rs   = 1'b0;
                nxt_data = CMD_ROW_ADDR;
            end
            4'd6:    nxt_data = 16'h0000;
            4'd7:    nxt_data = {8'h00, ys_r};
            4'd8:    nxt_data = {8'h00, ye_r[15:8]};
            4'd9:    nxt_data = {8'h00, ye_r[7:0]};
            4'd10: begin
                nxt_rs   = 1'b0;
                nxt_data = CMD_MEM_WRITE;
            end
            default: nxt_data = color_r.raw;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_busy     <= 1'b0;
            mlcd_cs_dri   <= 1'b1;
            mlcd_wr_dri   <= 1'b1;
            mlcd_rs_dri   <= 1'b0;
            mlcd_data_dri <= 16'd0;
            idx           <= 4'd0;
            pix_left      <= 16'd0;
            xs_r          <= 8'd0;
            xe_r          <= 16'd0;
            ys_r          <= 8'd0;
            ye_r          <= 16'd0;
            color_r.raw   <= 16'd0;
        end else if (!fill_busy) begin
            if (fill_start) begin           // Latch rectangle, send col cmd
                xs_r          <= x0;
                xe_r          <= 16'(x0) + 16'(w) - 16'd1;
                ys_r          <= y0;
                ye_r          <= 16'(y0) + 16'(h) - 16'd1;
                color_r       <= color;
                pix_left      <= 16'(w) * 16'(h);
                idx           <= 4'd0;
                fill_busy     <= 1'b1;
                mlcd_cs_dri   <= 1'b0;
                mlcd_wr_dri   <= 1'b0;
                mlcd_rs_dri   <= 1'b0;
                mlcd_data_dri <= CMD_COL_ADDR;
            end
        end else if (!mlcd_wr_dri) begin
            mlcd_wr_dri <= 1'b1;            // Second half of the word
        end else if (idx >= 4'd10 && pix_left == 16'd0) begin
            fill_busy   <= 1'b0;            // Last pixel done
            mlcd_cs_dri <= 1'b1;
        end else begin
            idx           <= nxt_idx;
            mlcd_rs_dri   <= nxt_rs;
            mlcd_data_dri <= nxt_data;
            mlcd_wr_dri   <= 1'b0;
            if (nxt_idx == 4'd11)
                pix_left <= pix_left - 16'd1;
        end
    end

endmodule

/* hw/lcd_init_seq.sv */
//----------------------------------------------------------------------------
// LCD init sequencer
// Panel reset pulse, ID read back, then the setup command list
//----------------------------------------------------------------------------

`timescale 1ns/1ns

module lcd_init_seq import lcd_pkg::*; #(
    parameter int RST_CYCLES = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] data_in_init,
    output logic        mlcd_cs_n_init,
    output logic        mlcd_wr_n_init,
    output logic        mlcd_rd_n_init,
    output logic        mlcd_rst_n_init,
    output logic        mlcd_rs_init,
    output logic        data_dir_init,      // 1 drives the bus
    output logic [15:0] data_out_init,
    output logic [15:0] panel_id,
    output logic        init_done
);

    typedef enum logic [2:0] {
        S_RST, S_WAIT, S_ID_CMD, S_ID_READ, S_SETUP, S_DONE
    } state_t;

    state_t      state;
    logic [15:0] cnt;
    logic [1:0]  idx;           // Setup table entry
    logic        param_ph;      // Parameter word of current entry

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= S_RST;
            cnt             <= 16'd0;
            idx             <= 2'd0;
            param_ph        <= 1'b0;
            mlcd_cs_n_init  <= 1'b1;
            mlcd_wr_n_init  <= 1'b1;
            mlcd_rd_n_init  <= 1'b1;
            mlcd_rst_n_init <= 1'b0;        // Panel held in reset
            mlcd_rs_init    <= 1'b0;
            data_dir_init   <= 1'b1;
            data_out_init   <= 16'd0;
            panel_id        <= 16'd0;
            init_done       <= 1'b0;
        end else begin
            case (state)
                S_RST: begin
                    cnt <= cnt + 16'd1;
                    if (cnt == 16'(RST_CYCLES - 1)) begin
                        mlcd_rst_n_init <= 1'b1;
                        cnt   <= 16'd0;
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin                   // Panel wake-up gap
                    cnt <= cnt + 16'd1;
                    if (cnt == 16'd3) begin
                        mlcd_cs_n_init <= 1'b0;
                        mlcd_wr_n_init <= 1'b0;
                        mlcd_rs_init   <= 1'b0;
                        data_out_init  <= CMD_READ_ID;
                        state          <= S_ID_CMD;
                    end
                end
                S_ID_CMD: begin
                    if (!mlcd_wr_n_init) begin
                        mlcd_wr_n_init <= 1'b1;
                    end else begin
                        data_dir_init  <= 1'b0; // Release bus to panel
                        mlcd_rd_n_init <= 1'b0;
                        mlcd_rs_init   <= 1'b1;
                        cnt            <= 16'd0;
                        state          <= S_ID_READ;
                    end
                end
                S_ID_READ: begin
                    cnt <= cnt + 16'd1;
                    if (cnt == 16'd1) begin     // Last rd_n low cycle
                        panel_id       <= data_in_init;
                        mlcd_rd_n_init <= 1'b1;
                        data_dir_init  <= 1'b1;
                        mlcd_wr_n_init <= 1'b0;
                        mlcd_rs_init   <= 1'b0;
                        data_out_init  <= INIT_CMDS[0];
                        idx            <= 2'd0;
                        param_ph       <= 1'b0;
                        state          <= S_SETUP;
                    end
                end
                S_SETUP: begin
                    if (!mlcd_wr_n_init) begin
                        mlcd_wr_n_init <= 1'b1;
                    end else if (!param_ph && INIT_PARAM_HAS[idx]) begin
                        param_ph       <= 1'b1;
                        mlcd_rs_init   <= 1'b1;
                        data_out_init  <= INIT_PARAMS[idx];
                        mlcd_wr_n_init <= 1'b0;
                    end else if (idx == 2'(INIT_CMD_NUM - 1)) begin
                        mlcd_cs_n_init <= 1'b1;
                        init_done      <= 1'b1; // Sticky until reset
                        state          <= S_DONE;
                    end else begin
                        idx            <= idx + 2'd1;
                        param_ph       <= 1'b0;
                        mlcd_rs_init   <= 1'b0;
                        data_out_init  <= INIT_CMDS[idx + 2'd1];
                        mlcd_wr_n_init <= 1'b0;
                    end
                end
                default: ;                      // S_DONE holds
            endcase
        end
    end

endmodule

/* hw/lcd_pkg.sv */
//----------------------------------------------------------------------------
// LCD shared definitions
// Register map, 8080 panel commands, setup table and the colour word
//----------------------------------------------------------------------------

package lcd_pkg;

    // RGB565 view of a pixel word
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } lcd_rgb_t;

    // One bus word, raw or as colour fields
    typedef union packed {
        logic [15:0] raw;
        lcd_rgb_t    rgb;
    } lcd_word_u;

    // APB byte offsets
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_ID     = 8'h08;
    localparam logic [7:0] REG_COLOR  = 8'h0C;
    localparam logic [7:0] REG_RECT   = 8'h10;

    // Panel commands
    localparam logic [15:0] CMD_COL_ADDR  = 16'h002A;
    localparam logic [15:0] CMD_ROW_ADDR  = 16'h002B;
    localparam logic [15:0] CMD_MEM_WRITE = 16'h002C;
    localparam logic [15:0] CMD_READ_ID   = 16'h00D3;

    // Setup list, entry 0 goes out first
    localparam int INIT_CMD_NUM = 4;
    localparam logic [INIT_CMD_NUM-1:0][15:0] INIT_CMDS =
        {16'h0029, 16'h003A, 16'h0036, 16'h0011};    // Display on .. sleep out
    localparam logic [INIT_CMD_NUM-1:0] INIT_PARAM_HAS = 4'b0110;
    localparam logic [INIT_CMD_NUM-1:0][15:0] INIT_PARAMS =
        {16'h0000, 16'h0055, 16'h0000, 16'h0000};    // 16 bpp, default MADCTL

endpackage

/* hw/lcd_signal_sel.sv */
//----------------------------------------------------------------------------
// LCD pin selector
// Hands the panel pins to init or fill driver, owns the tristate bus
//----------------------------------------------------------------------------

`timescale 1ns/1ns

module lcd_signal_sel (
    inout  wire  [15:0] mlcd_data,
    input  logic        mlcd_cs_n_init,
    input  logic        mlcd_wr_n_init,
    input  logic        mlcd_rd_n_init,
    input  logic        mlcd_rst_n_init,
    input  logic        mlcd_rs_init,
    input  logic        mlcd_data_dir_init,
    input  logic [15:0] mlcd_data_out_init,
    input  logic        init_done,
    input  logic        bl,
    input  logic        mlcd_cs_dri,
    input  logic        mlcd_wr_dri,
    input  logic        mlcd_rs_dri,
    input  logic [15:0] mlcd_data_dri,
    output logic        mlcd_cs_n,
    output logic        mlcd_wr_n,
    output logic        mlcd_rd_n,
    output logic        mlcd_rs,
    output logic        mlcd_rst_n,
    output logic        mlcd_bl,
    output logic [15:0] mlcd_data_in_init
);

    logic        data_dir;
    logic [15:0] data_out;

    // Fill phase writes only, so bus stays driven
    assign data_dir  = init_done ? 1'b1 : mlcd_data_dir_init;
    assign data_out  = init_done ? mlcd_data_dri : mlcd_data_out_init;
    assign mlcd_data = data_dir ? data_out : 16'hzzzz;
    assign mlcd_data_in_init = mlcd_data;                   // ID read path

    assign mlcd_cs_n  = init_done ? mlcd_cs_dri : mlcd_cs_n_init;
    assign mlcd_wr_n  = init_done ? mlcd_wr_dri : mlcd_wr_n_init;
    assign mlcd_rs    = init_done ? mlcd_rs_dri : mlcd_rs_init;
    assign mlcd_rd_n  = init_done ? 1'b1 : mlcd_rd_n_init;       // No reads
    assign mlcd_rst_n = init_done ? 1'b1 : mlcd_rst_n_init;      // Released
    assign mlcd_bl    = bl;                                      // CTRL bit1

endmodule

/* hw/lcd_top.sv */
//----------------------------------------------------------------------------
// LCD subsystem top
// APB control, init sequencer, fill driver and pin selector
//----------------------------------------------------------------------------

`timescale 1ns/1ns

module lcd_top import lcd_pkg::*; #(
    parameter int RST_CYCLES = 8
) (
    input  logic        clk,            // Also APB pclk
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    inout  wire  [15:0] mlcd_data,
    output logic        mlcd_bl,
    output logic        mlcd_cs_n,
    output logic        mlcd_wr_n,
    output logic        mlcd_rd_n,
    output logic        mlcd_rs,
    output logic        mlcd_rst_n
);

    // Init pin set
    logic        cs_n_init, wr_n_init, rd_n_init, rst_n_init, rs_init;
    logic        data_dir_init;
    logic [15:0] data_out_init, data_in_init;
    logic [15:0] panel_id;
    logic        init_done;
    // Control to fill driver
    logic        fill_start, fill_busy, bl;
    lcd_word_u   color;
    logic [7:0]  x0, y0, w, h;
    // Fill driver pin set
    logic        cs_dri, wr_dri, rs_dri;
    logic [15:0] data_dri;

    lcd_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .init_done(init_done), .fill_busy(fill_busy), .panel_id(panel_id),
        .fill_start(fill_start), .bl(bl), .color(color),
        .x0(x0), .y0(y0), .w(w), .h(h)
    );

    lcd_init_seq #(.RST_CYCLES(RST_CYCLES)) u_init_seq (
        .clk(clk), .rst_n(rst_n), .data_in_init(data_in_init),
        .mlcd_cs_n_init(cs_n_init), .mlcd_wr_n_init(wr_n_init),
        .mlcd_rd_n_init(rd_n_init), .mlcd_rst_n_init(rst_n_init),
        .mlcd_rs_init(rs_init), .data_dir_init(data_dir_init),
        .data_out_init(data_out_init), .panel_id(panel_id), .init_done(init_done)
    );

    lcd_fill_dri u_fill_dri (
        .clk(clk), .rst_n(rst_n), .fill_start(fill_start), .color(color),
        .x0(x0), .y0(y0), .w(w), .h(h), .fill_busy(fill_busy),
        .mlcd_cs_dri(cs_dri), .mlcd_wr_dri(wr_dri), .mlcd_rs_dri(rs_dri),
        .mlcd_data_dri(data_dri)
    );

    lcd_signal_sel u_signal_sel (
        .mlcd_data(mlcd_data),
        .mlcd_cs_n_init(cs_n_init), .mlcd_wr_n_init(wr_n_init),
        .mlcd_rd_n_init(rd_n_init), .mlcd_rst_n_init(rst_n_init),
        .mlcd_rs_init(rs_init), .mlcd_data_dir_init(data_dir_init),
        .mlcd_data_out_init(data_out_init), .init_done(init_done), .bl(bl),
        .mlcd_cs_dri(cs_dri), .mlcd_wr_dri(wr_dri), .mlcd_rs_dri(rs_dri),
        .mlcd_data_dri(data_dri),
        .mlcd_cs_n(mlcd_cs_n), .mlcd_wr_n(mlcd_wr_n), .mlcd_rd_n(mlcd_rd_n),
        .mlcd_rs(mlcd_rs), .mlcd_rst_n(mlcd_rst_n), .mlcd_bl(mlcd_bl),
        .mlcd_data_in_init(data_in_init)
    );

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the LCD testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lcd_tb -f files.f
./obj_dir/Vlcd_tb | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* test/lcd_chk.sv */
//----------------------------------------------------------------------------
// LCD panel bus checker
// Concurrent assertions on the 8080 strobes, bound into lcd_top
//----------------------------------------------------------------------------

`timescale 1ns/1ns

module lcd_chk (
    input logic clk,
    input logic rst_n,
    input logic mlcd_cs_n,
    input logic mlcd_wr_n,
    input logic mlcd_rd_n,
    input logic init_done
);

    a_wr_rd_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(!mlcd_wr_n && !mlcd_rd_n))           // Strobes never overlap
        else $error("wr_n and rd_n low at the same time");

    a_wr_cs: assert property (@(posedge clk) disable iff (!rst_n)
        !mlcd_wr_n |-> !mlcd_cs_n)             // Writes only inside a group
        else $error("wr_n low while cs_n high");

    // Write strobe is a single low cycle
    a_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        !mlcd_wr_n |=> mlcd_wr_n)
        else $error("wr_n low for more than one cycle");

    // Init done holds, so the fill phase keeps the pins and never reads
    a_no_rd: assert property (@(posedge clk) disable iff (!rst_n)
        init_done |=> init_done && mlcd_rd_n)
        else $error("init_done dropped or rd_n low after init_done");

endmodule

bind lcd_top lcd_chk chk0 (
    .clk(clk), .rst_n(rst_n), .mlcd_cs_n(mlcd_cs_n), .mlcd_wr_n(mlcd_wr_n),
    .mlcd_rd_n(mlcd_rd_n), .init_done(init_done)
);

/* test/lcd_tb.sv */
//----------------------------------------------------------------------------
// LCD subsystem testbench
// APB driver, 8080 panel model, init and random fill checks
//----------------------------------------------------------------------------

`timescale 1ns/1ns

module lcd_tb import lcd_pkg::*; ();

    localparam logic [15:0] PANEL_ID  = 16'h9341;
    localparam int          MAX_POLLS = 200;     // STATUS reads per wait

    logic        clk;
    logic        rst_n;
    logic        psel, penable, pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready, pslverr;
    wire  [15:0] mlcd_data;
    logic        mlcd_bl, mlcd_cs_n, mlcd_wr_n, mlcd_rd_n, mlcd_rs, mlcd_rst_n;

    integer      seed = 22789;
    logic        cap_rs[$];      // Words seen by the panel
    lcd_word_u   cap_data[$];
    logic        exp_rs[$];      // Words the model predicts
    lcd_word_u   exp_data[$];

    lcd_top #(.RST_CYCLES(8)) dut0 (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .mlcd_data(mlcd_data), .mlcd_bl(mlcd_bl), .mlcd_cs_n(mlcd_cs_n),
        .mlcd_wr_n(mlcd_wr_n), .mlcd_rd_n(mlcd_rd_n), .mlcd_rs(mlcd_rs),
        .mlcd_rst_n(mlcd_rst_n)
    );

    always #2 clk = ~clk;                       // 4 ns period

    // ------------------------------------------------------------------------
    // Panel model
    // ------------------------------------------------------------------------
    assign mlcd_data = (!mlcd_rd_n && !mlcd_cs_n) ? PANEL_ID : 16'hzzzz;

    // Panel latches rs and data on the rising wr_n edge
    always @(posedge mlcd_wr_n) begin
        if (rst_n) begin
            cap_rs.push_back(mlcd_rs);
            cap_data.push_back(mlcd_data);
        end
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input lcd_word_u got, input lcd_word_u exp);
        if (got.raw !== exp.raw)
            stop_with_error($sformatf("Error at %0t ns: %s = %h, expected %h",
                                      $time, name, got.raw, exp.raw));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_error($sformatf("Error at %0t ns: %s = %b, expected %b",
                                      $time, name, got, exp));
    endtask

    task automatic check_resp(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_error($sformatf("Error at %0t ns: %s = %b, expected %b",
                                      $time, name, got, exp));
    endtask

    task automatic check_reg(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("Error at %0t ns: %s = %h, expected %h",
                                      $time, name, got, exp));
    endtask

    // ------------------------------------------------------------------------
    // APB master
    // ------------------------------------------------------------------------
    task automatic apb_xfer(input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;                         // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;                         // Access phase
        #1;
        check_bit("pready", pready, 1'b1);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] rd_unused;
        apb_xfer(1'b1, addr, data, rd_unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        apb_xfer(1'b0, addr, 32'd0, data, err);
    endtask

    // Poll one STATUS bit until it reaches the level
    task automatic wait_status(input int bit_idx, input logic level, input string what);
        logic [31:0] rd;
        logic        err;
        int          n;
        n = 0;
        apb_read(REG_STATUS, rd, err);
        while (rd[bit_idx] !== level && n < MAX_POLLS) begin
            apb_read(REG_STATUS, rd, err);
            n++;
        end
        if (rd[bit_idx] !== level)
            stop_with_error($sformatf("Timeout: %s did not happen in %0d polls",
                                      what, MAX_POLLS));
    endtask

    // ------------------------------------------------------------------------
    // Reference model of the panel word stream
    // ------------------------------------------------------------------------
    task automatic expect_word(input logic rs, input logic [15:0] data);
        lcd_word_u wd;
        wd.raw = data;
        exp_rs.push_back(rs);
        exp_data.push_back(wd);
    endtask

    task automatic expect_fill(input lcd_word_u col, input logic [7:0] x, input logic [7:0] y,
                               input logic [7:0] wd, input logic [7:0] ht);
        logic [15:0] x_end;
        logic [15:0] y_end;
        int          npix;
        x_end = {8'd0, x} + {8'd0, wd} - 16'd1;
        y_end = {8'd0, y} + {8'd0, ht} - 16'd1;
        npix  = int'(wd) * int'(ht);
        expect_word(1'b0, CMD_COL_ADDR);
        expect_word(1'b1, 16'h0000);            // x0 high byte
        expect_word(1'b1, {8'd0, x});
        expect_word(1'b1, {8'd0, x_end[15:8]});
        expect_word(1'b1, {8'd0, x_end[7:0]});
        expect_word(1'b0, CMD_ROW_ADDR);
        expect_word(1'b1, 16'h0000);
        expect_word(1'b1, {8'd0, y});
        expect_word(1'b1, {8'd0, y_end[15:8]});
        expect_word(1'b1, {8'd0, y_end[7:0]});
        expect_word(1'b0, CMD_MEM_WRITE);
        for (int i = 0; i < npix; i++)
            expect_word(1'b1, col.raw);
    endtask

    task automatic compare_capture(input string what);
        if (cap_data.size() != exp_data.size())
            stop_with_error($sformatf("%s: panel received %0d words but %0d were expected",
                                      what, cap_data.size(), exp_data.size()));
        foreach (exp_data[i]) begin
            check_bit($sformatf("mlcd_rs[%0d]", i), cap_rs[i], exp_rs[i]);
            check_word($sformatf("mlcd_data[%0d]", i), cap_data[i], exp_data[i]);
        end
        cap_rs.delete();
        cap_data.delete();
        exp_rs.delete();
        exp_data.delete();
    endtask

    // One random rectangle; second start optionally lands while busy
    task automatic run_fill(input logic restart);
        lcd_word_u   col;
        logic [7:0]  x, y, wd, ht;
        logic [31:0] rd;
        logic        err;
        col.rgb.red   = 5'($random(seed));
        col.rgb.green = 6'($random(seed));
        col.rgb.blue  = 5'($random(seed));
        x  = 8'({$random(seed)} % 201);
        y  = 8'({$random(seed)} % 201);
        wd = 8'({$random(seed)} % 6 + 1);
        ht = 8'({$random(seed)} % 6 + 1);
        apb_write(REG_COLOR, {16'd0, col.raw}, err);
        apb_write(REG_RECT, {ht, wd, y, x}, err);
        apb_read(REG_COLOR, rd, err);
        check_reg("COLOR", rd, {16'd0, col.raw});
        apb_read(REG_RECT, rd, err);
        check_reg("RECT", rd, {ht, wd, y, x});
        expect_fill(col, x, y, wd, ht);
        apb_write(REG_CTRL, 32'h3, err);        // Start, backlight on
        if (restart)
            apb_write(REG_CTRL, 32'h3, err);    // Must be ignored
        apb_read(REG_STATUS, rd, err);
        check_bit("STATUS.busy", rd[1], 1'b1);  // Shortest fill is 24 cycles
        wait_status(1, 1'b0, "busy clear after fill");
        // Every word is on the panel once busy reads low
        if (cap_data.size() != exp_data.size())
            stop_with_error($sformatf("busy cleared after %0d of %0d panel words",
                                      cap_data.size(), exp_data.size()));
        repeat (20) @(posedge clk);             // Quiet gap, no stray words
        compare_capture("fill");
        check_bit("mlcd_bl", mlcd_bl, 1'b1);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] rd;
        logic        err;
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'd0;
        pwdata  = 32'd0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle pins, panel still in reset
        check_bit("mlcd_cs_n", mlcd_cs_n, 1'b1);
        check_bit("mlcd_wr_n", mlcd_wr_n, 1'b1);
        check_bit("mlcd_rd_n", mlcd_rd_n, 1'b1);
        check_bit("mlcd_rst_n", mlcd_rst_n, 1'b0);
        check_bit("mlcd_bl", mlcd_bl, 1'b0);
        check_resp("pslverr", pslverr, 1'b0);
        check_reg("prdata", prdata, 32'd0);
        apb_read(REG_STATUS, rd, err);
        check_reg("STATUS", rd, 32'd0);

        wait_status(0, 1'b1, "init_done");
        check_bit("mlcd_rst_n", mlcd_rst_n, 1'b1);
        apb_read(REG_ID, rd, err);
        check_word("ID", rd[15:0], PANEL_ID);

        // ID command, then the setup list
        expect_word(1'b0, CMD_READ_ID);
        expect_word(1'b0, 16'h0011);            // Sleep out
        expect_word(1'b0, 16'h0036);            // MADCTL
        expect_word(1'b1, 16'h0000);
        expect_word(1'b0, 16'h003A);            // Pixel format
        expect_word(1'b1, 16'h0055);
        expect_word(1'b0, 16'h0029);            // Display on
        compare_capture("init");

        // Backlight
        apb_write(REG_CTRL, 32'h2, err);
        check_bit("mlcd_bl", mlcd_bl, 1'b1);
        apb_read(REG_CTRL, rd, err);
        check_reg("CTRL", rd, 32'h2);
        apb_write(REG_CTRL, 32'h0, err);
        check_bit("mlcd_bl", mlcd_bl, 1'b0);

        for (int i = 0; i < 10; i++)
            run_fill(1'b0);
        run_fill(1'b1);                         // Start while busy

        // Unmapped and mapped responses
        apb_read(8'h14, rd, err);
        check_resp("pslverr", err, 1'b1);
        apb_write(8'h14, 32'hFFFF_FFFF, err);
        check_resp("pslverr", err, 1'b1);
        apb_read(REG_ID, rd, err);
        check_resp("pslverr", err, 1'b0);
        apb_write(REG_COLOR, 32'h0000_1234, err);
        check_resp("pslverr", err, 1'b0);

        $display("NO ERRORS");
        $finish;
    end

endmodule
